/* rtl/core_cfg_pkg.sv */
package core_cfg_pkg;

    // architectural register file
    localparam int NUM_REGS   = 16;
    localparam int REG_ADDR_W = 4;
    localparam int WORD_W     = 32;

    // history file geometry, one slot stays unused so full and empty differ
    localparam int HF_SIZE = 8;
    localparam int HF_PTR  = 3;

    // execution pipes
    localparam int NUM_PIPES  = 3;
    localparam int PIPE_SEL_W = 2;

    // fixed latency of each pipe, indexed by pipe number
    localparam int PIPE_DEPTH [NUM_PIPES] = '{1, 3, 5};

endpackage : core_cfg_pkg

/* rtl/core_types_pkg.sv */
package core_types_pkg;

    import core_cfg_pkg::*;

    // decoded instruction with its result already known
    typedef struct packed {
        logic [REG_ADDR_W-1:0] dest;
        logic [WORD_W-1:0]     value;
        logic [PIPE_SEL_W-1:0] pipe_sel;
        logic                  exc;
    } instr_t;

    // entry written into the history file on issue
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] dest;
        logic [WORD_W-1:0]     old_value;
    } hf_alloc_t;

    // op travelling through an execution pipe
    typedef struct packed {
        logic                  valid;
        logic [HF_PTR-1:0]     id;
        logic [REG_ADDR_W-1:0] dest;
        logic [WORD_W-1:0]     value;
        logic                  exc;
    } pipe_op_t;

    // completion report for one history entry
    typedef struct packed {
        logic              valid;
        logic [HF_PTR-1:0] id;
        logic              exc;
    } cpl_t;

    // one register write during rollback
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] dest;
        logic [WORD_W-1:0]     value;
    } restore_t;

    typedef enum logic [1:0] {
        EMPTY,
        EXECUTING,
        EXEC_OK,
        EXCEPTION
    } entry_status_e;

endpackage : core_types_pkg

/* rtl/exec_pipe.sv */
`timescale 1ns/1ps

module exec_pipe #(
    parameter int DEPTH = 1
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     flush_i,
    input  core_types_pkg::pipe_op_t op_i,
    output core_types_pkg::pipe_op_t op_o
);

    import core_types_pkg::*;

    pipe_op_t stage [DEPTH];

    // plain shift chain, every op leaves after exactly DEPTH edges
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= op_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
            // a flush kills everything in flight, payload may stay stale
            if (flush_i) begin
                for (int i = 0; i < DEPTH; i++) begin
                    stage[i].valid <= 1'b0;
                end
            end
        end
    end

    assign op_o = stage[DEPTH-1];

endmodule : exec_pipe

/* rtl/history_file.sv */
`timescale 1ns/1ps

module history_file (
    input  logic                                             clk_i,
    input  logic                                             arst_n_i,
    input  core_types_pkg::hf_alloc_t                        alloc_i,
    output logic [core_cfg_pkg::HF_PTR-1:0]                  alloc_id_o,
    input  core_types_pkg::cpl_t [core_cfg_pkg::NUM_PIPES-1:0] cpl_i,
    output logic                                             full_o,
    output logic                                             empty_o,
    output logic                                             recovering_o,
    output core_types_pkg::restore_t                         restore_o
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    typedef enum logic {
        HF_NORMAL,
        HF_RECOVER
    } hf_state_e;

    hf_state_e             state;
    hf_state_e             nxt_state;
    entry_status_e         status [HF_SIZE];
    logic [REG_ADDR_W-1:0] entry_dest [HF_SIZE];
    logic [WORD_W-1:0]     entry_old [HF_SIZE];
    logic [HF_PTR-1:0]     head;
    logic [HF_PTR-1:0]     tail;
    logic [HF_PTR-1:0]     nxt_head;
    logic [HF_PTR-1:0]     youngest;
    logic [HF_SIZE-1:0]    cpl_ok;

    assign empty_o      = (head == tail);
    assign full_o       = (tail + HF_PTR'(1)) == head;
    assign youngest     = tail - HF_PTR'(1);
    assign alloc_id_o   = tail;
    assign recovering_o = (state == HF_RECOVER);

    // rollback walks from the youngest entry towards the head
    assign restore_o.valid = (state == HF_RECOVER) && !empty_o;
    assign restore_o.dest  = entry_dest[youngest];
    assign restore_o.value = entry_old[youngest];

    always_comb begin
        cpl_ok = '0;
        for (int p = 0; p < NUM_PIPES; p++) begin
            if (cpl_i[p].valid && !cpl_i[p].exc) begin
                cpl_ok[cpl_i[p].id] = 1'b1;
            end
        end
    end

    // retire the leading run of finished entries, counting this cycle's completions
    always_comb begin : retire_scan
        logic              run;
        logic [HF_PTR-1:0] ptr;
        nxt_head = head;
        run      = 1'b1;
        for (int i = 0; i < HF_SIZE - 1; i++) begin
            ptr = head + HF_PTR'(i);
            if (run && ptr != tail && (status[ptr] == EXEC_OK || cpl_ok[ptr])) begin
                nxt_head = ptr + HF_PTR'(1);
            end else begin
                run = 1'b0;
            end
        end
    end

    // the last restore and the return to normal share one edge
    always_comb begin
        nxt_state = state;
        case (state)
            HF_NORMAL: begin
                if (!empty_o && status[head] == EXCEPTION) begin
                    nxt_state = HF_RECOVER;
                end
            end
            HF_RECOVER: begin
                if (empty_o || youngest == head) begin
                    nxt_state = HF_NORMAL;
                end
            end
            default: nxt_state = HF_NORMAL;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= HF_NORMAL;
            head  <= '0;
            tail  <= '0;
            for (int i = 0; i < HF_SIZE; i++) begin
                status[i] <= EMPTY;
            end
        end else begin
            state <= nxt_state;
            if (state == HF_NORMAL) begin
                head <= nxt_head;
                if (alloc_i.valid) begin
                    status[tail] <= EXECUTING;
                    tail         <= tail + HF_PTR'(1);
                end
                for (int p = 0; p < NUM_PIPES; p++) begin
                    if (cpl_i[p].valid) begin
                        status[cpl_i[p].id] <= cpl_i[p].exc ? EXCEPTION : EXEC_OK;
                    end
                end
            end else if (!empty_o) begin
                status[youngest] <= EMPTY;
                tail             <= youngest;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == HF_NORMAL && alloc_i.valid) begin
            entry_dest[tail] <= alloc_i.dest;
            entry_old[tail]  <= alloc_i.old_value;
        end
    end

endmodule : history_file

/* rtl/issue_unit.sv */
`timescale 1ns/1ps

module issue_unit (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,
    input  logic                                                 instr_valid_i,
    input  core_types_pkg::instr_t                               instr_i,
    output logic                                                 issue_ready_o,
    input  logic                                                 full_i,
    input  logic                                                 recovering_i,
    input  logic [core_cfg_pkg::HF_PTR-1:0]                      alloc_id_i,
    input  core_types_pkg::cpl_t [core_cfg_pkg::NUM_PIPES-1:0]     cpl_i,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0]                  rd_addr_o,
    input  logic [core_cfg_pkg::WORD_W-1:0]                      rd_data_i,
    output core_types_pkg::hf_alloc_t                            alloc_o,
    output core_types_pkg::pipe_op_t [core_cfg_pkg::NUM_PIPES-1:0] pipe_in_o
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    logic [NUM_REGS-1:0]   busy;
    logic [REG_ADDR_W-1:0] dest_of_id [HF_SIZE];
    logic [PIPE_SEL_W-1:0] target;
    logic                  accept;

    // a register with a result still in flight blocks a new writer
    assign issue_ready_o = !full_i && !recovering_i && !busy[instr_i.dest];
    assign accept        = instr_valid_i && issue_ready_o;

    // an out of range selector falls back to the slowest pipe
    assign target = (instr_i.pipe_sel < PIPE_SEL_W'(NUM_PIPES)) ?
                    instr_i.pipe_sel : PIPE_SEL_W'(NUM_PIPES - 1);

    // old value of the destination goes into the history entry
    assign rd_addr_o         = instr_i.dest;
    assign alloc_o.valid     = accept;
    assign alloc_o.dest      = instr_i.dest;
    assign alloc_o.old_value = rd_data_i;

    always_comb begin
        for (int p = 0; p < NUM_PIPES; p++) begin
            pipe_in_o[p].valid = accept && (target == PIPE_SEL_W'(p));
            pipe_in_o[p].id    = alloc_id_i;
            pipe_in_o[p].dest  = instr_i.dest;
            pipe_in_o[p].value = instr_i.value;
            pipe_in_o[p].exc   = instr_i.exc;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dest_of_id[alloc_id_i] <= instr_i.dest;
        end
    end

    // recovery flushes every pipe, so nothing stays pending
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy <= '0;
        end else if (recovering_i) begin
            busy <= '0;
        end else begin
            for (int p = 0; p < NUM_PIPES; p++) begin
                if (cpl_i[p].valid) begin
                    busy[dest_of_id[cpl_i[p].id]] <= 1'b0;
                end
            end
            if (accept) begin
                busy[instr_i.dest] <= 1'b1;
            end
        end
    end

endmodule : issue_unit

/* rtl/precise_core_top.sv */
`timescale 1ns/1ps

module precise_core_top (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                instr_valid_i,
    input  core_types_pkg::instr_t              instr_i,
    output logic                                issue_ready_o,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] dbg_addr_i,
    output logic [core_cfg_pkg::WORD_W-1:0]     dbg_data_o,
    output logic                                full_o,
    output logic                                empty_o,
    output logic                                recovering_o
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    hf_alloc_t                 alloc;
    logic [HF_PTR-1:0]         alloc_id;
    pipe_op_t [NUM_PIPES-1:0]  pipe_in;
    pipe_op_t [NUM_PIPES-1:0]  pipe_out;
    cpl_t [NUM_PIPES-1:0]      cpl;
    restore_t                  restore;
    logic                      recovering;
    logic [REG_ADDR_W-1:0]     rd_addr;
    logic [WORD_W-1:0]         rd_data;

    assign recovering_o = recovering;

    issue_unit u_issue (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .issue_ready_o (issue_ready_o),
        .full_i        (full_o),
        .recovering_i  (recovering),
        .alloc_id_i    (alloc_id),
        .cpl_i         (cpl),
        .rd_addr_o     (rd_addr),
        .rd_data_i     (rd_data),
        .alloc_o       (alloc),
        .pipe_in_o     (pipe_in)
    );

    // pipes differ only in latency
    for (genvar p = 0; p < NUM_PIPES; p++) begin : g_pipe
        exec_pipe #(
            .DEPTH (PIPE_DEPTH[p])
        ) u_pipe (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .flush_i  (recovering),
            .op_i     (pipe_in[p]),
            .op_o     (pipe_out[p])
        );
    end

    history_file u_history (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .alloc_i      (alloc),
        .alloc_id_o   (alloc_id),
        .cpl_i        (cpl),
        .full_o       (full_o),
        .empty_o      (empty_o),
        .recovering_o (recovering),
        .restore_o    (restore)
    );

    writeback_unit u_writeback (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .pipe_out_i   (pipe_out),
        .recovering_i (recovering),
        .restore_i    (restore),
        .cpl_o        (cpl),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data),
        .dbg_addr_i   (dbg_addr_i),
        .dbg_data_o   (dbg_data_o)
    );

endmodule : precise_core_top

/* rtl/writeback_unit.sv */
`timescale 1ns/1ps

module writeback_unit (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,
    input  core_types_pkg::pipe_op_t [core_cfg_pkg::NUM_PIPES-1:0] pipe_out_i,
    input  logic                                                 recovering_i,
    input  core_types_pkg::restore_t                             restore_i,
    output core_types_pkg::cpl_t [core_cfg_pkg::NUM_PIPES-1:0]     cpl_o,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0]                  rd_addr_i,
    output logic [core_cfg_pkg::WORD_W-1:0]                      rd_data_o,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0]                  dbg_addr_i,
    output logic [core_cfg_pkg::WORD_W-1:0]                      dbg_data_o
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    logic [WORD_W-1:0] regs [NUM_REGS];

    assign rd_data_o  = regs[rd_addr_i];
    assign dbg_data_o = regs[dbg_addr_i];

    // results still in the pipes are dead once rollback has started
    always_comb begin
        for (int p = 0; p < NUM_PIPES; p++) begin
            cpl_o[p].valid = pipe_out_i[p].valid && !recovering_i;
            cpl_o[p].id    = pipe_out_i[p].id;
            cpl_o[p].exc   = pipe_out_i[p].exc;
        end
    end

    // the scoreboard keeps two pipes from ever writing the same register at once
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (recovering_i) begin
            if (restore_i.valid) begin
                regs[restore_i.dest] <= restore_i.value;
            end
        end else begin
            for (int p = 0; p < NUM_PIPES; p++) begin
                // a faulting op leaves its destination untouched
                if (pipe_out_i[p].valid && !pipe_out_i[p].exc) begin
                    regs[pipe_out_i[p].dest] <= pipe_out_i[p].value;
                end
            end
        end
    end

endmodule : writeback_unit

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_precise_core -f sources.f \
    --Mdir obj_dir -o sim_precise_core \
    && ./obj_dir/sim_precise_core | tee sim.log

grep -q "^TEST OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sources.f */
rtl/core_cfg_pkg.sv
rtl/core_types_pkg.sv
rtl/issue_unit.sv
rtl/exec_pipe.sv
rtl/history_file.sv
rtl/writeback_unit.sv
rtl/precise_core_top.sv
verif/tb_precise_core.sv

/* verif/tb_precise_core.sv */
`timescale 1ns/1ps

module tb_precise_core;

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    localparam int RUN_INSTRS   = 2000;
    localparam int BURST_INSTRS = 200;
    localparam int DRAIN_EVERY  = 50;
    // eight cycles per instruction plus room for register sweeps and recoveries
    localparam int CYCLE_LIMIT  = (RUN_INSTRS + BURST_INSTRS) * 8 + 4000;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  instr_valid_i;
    instr_t                instr_i;
    logic                  issue_ready_o;
    logic [REG_ADDR_W-1:0] dbg_addr_i;
    logic [WORD_W-1:0]     dbg_data_o;
    logic                  full_o;
    logic                  empty_o;
    logic                  recovering_o;

    // accepted instructions in program order and the committed registers of the model
    instr_t                order_q [$];
    logic [WORD_W-1:0]     arch [NUM_REGS];

    bit pending;
    bit seen_rec;
    bit seen_empty;
    bit check_len;
    int since_empty;
    int rec_entries;
    int rec_cycles;
    int rec_count;
    int cycle_count;

    precise_core_top UUT (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .issue_ready_o (issue_ready_o),
        .dbg_addr_i    (dbg_addr_i),
        .dbg_data_o    (dbg_data_o),
        .full_o        (full_o),
        .empty_o       (empty_o),
        .recovering_o  (recovering_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("the run timed out after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic instr_t make_instr(input int dest, input logic [WORD_W-1:0] value,
                                          input int pipe, input logic exc);
        instr_t ins;
        ins.dest     = REG_ADDR_W'(dest);
        ins.value    = value;
        ins.pipe_sel = PIPE_SEL_W'(pipe);
        ins.exc      = exc;
        return ins;
    endfunction

    // roughly one faulting instruction in forty when faults are allowed
    function automatic instr_t random_instr(input bit allow_exc);
        instr_t ins;
        ins.dest     = REG_ADDR_W'($urandom_range(0, NUM_REGS - 1));
        ins.value    = $urandom;
        ins.pipe_sel = PIPE_SEL_W'($urandom_range(0, NUM_PIPES - 1));
        ins.exc      = allow_exc && ($urandom_range(0, 39) == 0);
        return ins;
    endfunction

    // commit in order up to the oldest fault and drop that fault and everything younger
    task automatic settle_model();
        instr_t ins;
        while (order_q.size() > 0) begin
            ins = order_q.pop_front();
            if (ins.exc) begin
                order_q.delete();
            end else begin
                arch[ins.dest] = ins.value;
            end
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < NUM_REGS; r++) begin
            @(negedge clk_i);
            instr_valid_i = 1'b0;
            dbg_addr_i    = REG_ADDR_W'(r);
            #10;
            check_word(dbg_data_o, arch[r], $sformatf("register r%0d", r));
        end
    endtask

    // inputs change at the falling edge and outputs are sampled a little later in the low phase
    task automatic run_cycle(input bit drive, input instr_t fresh, output bit accepted);
        bit will_accept;
        bit fell;
        @(negedge clk_i);
        // a request waits out a rollback so the registers stay still for the sweep after it
        if (!drive || seen_rec) begin
            instr_valid_i = 1'b0;
        end else begin
            if (!pending) begin
                instr_i = fresh;
            end
            instr_valid_i = 1'b1;
        end
        #1;
        if (full_o || recovering_o) begin
            check_flag(issue_ready_o, 1'b0, "issue_ready_o while full or recovering");
        end
        if (empty_o) begin
            since_empty = 0;
        end
        if (recovering_o && !seen_rec) begin
            rec_entries = since_empty;
            rec_cycles  = 0;
            rec_count++;
            settle_model();
        end
        if (recovering_o) begin
            rec_cycles++;
        end
        fell = seen_rec && !recovering_o;
        if (fell) begin
            check_flag(empty_o, 1'b1, "empty_o after recovery");
            if (check_len) begin
                check_word(WORD_W'(rec_cycles), WORD_W'(rec_entries), "recovery cycles");
            end
        end
        seen_rec    = recovering_o;
        seen_empty  = empty_o;
        will_accept = instr_valid_i && issue_ready_o;
        @(posedge clk_i);
        if (will_accept) begin
            order_q.push_back(instr_i);
            since_empty++;
        end
        if (!drive) begin
            pending = 1'b0;
        end else if (instr_valid_i) begin
            pending = !will_accept;
        end
        accepted = will_accept;
        if (fell) begin
            check_regs();
        end
    endtask

    task automatic issue_one(input instr_t ins);
        bit acc;
        acc = 1'b0;
        while (!acc) begin
            run_cycle(1'b1, ins, acc);
        end
    endtask

    task automatic drain();
        bit acc;
        bit idle;
        idle = 1'b0;
        while (!idle) begin
            run_cycle(1'b0, '0, acc);
            idle = seen_empty && !seen_rec;
        end
        settle_model();
        check_regs();
    endtask

    initial begin
        bit acc;
        int n;
        int start_count;
        void'($urandom(79));
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        dbg_addr_i    = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            arch[r] = '0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        #1;
        check_flag(empty_o, 1'b1, "empty_o after reset");
        check_flag(full_o, 1'b0, "full_o after reset");
        check_flag(recovering_o, 1'b0, "recovering_o after reset");
        check_flag(issue_ready_o, 1'b1, "issue_ready_o after reset");
        check_regs();

        // a fault-free burst lets all three pipes complete out of order
        n = 0;
        while (n < BURST_INSTRS) begin
            run_cycle(1'b1, random_instr(1'b0), acc);
            if (acc) begin
                n++;
            end
        end
        drain();
        check_flag(logic'(rec_count == 0), 1'b1, "no recovery during fault-free burst");

        // oldest op faults on the slowest pipe while two younger ops finish first
        check_len   = 1'b1;
        start_count = rec_count;
        issue_one(make_instr(1, 32'h1111_0001, 2, 1'b1));
        issue_one(make_instr(2, 32'h2222_0002, 0, 1'b0));
        issue_one(make_instr(3, 32'h3333_0003, 1, 1'b0));
        drain();
        check_flag(logic'(rec_count == start_count + 1), 1'b1, "recovering_o rose for the fault");
        check_len = 1'b0;

        n = 0;
        while (n < RUN_INSTRS) begin
            run_cycle(1'b1, random_instr(1'b1), acc);
            if (acc) begin
                n++;
                if (n % DRAIN_EVERY == 0) begin
                    drain();
                end
            end
        end
        drain();

        $display("TEST OK");
        $finish;
    end

endmodule : tb_precise_core
